//--- sdr_frontend_macros.svh
`ifndef SDR_FRONTEND_MACROS_SVH
`define SDR_FRONTEND_MACROS_SVH

// Datapath widths
`define SDR_SAMPLE_BITS     8
`define SDR_PHASE_BITS      32

// APB window, upper address half
`define SDR_APB_WINDOW      16'h43C0

// Register pages in paddr[15:12]
`define SDR_PAGE_CHA        4'h0
`define SDR_PAGE_CHB        4'h1
`define SDR_PAGE_DDS        4'h2
`define SDR_PAGE_STATUS     4'h3

// IO expander link timing and slave address
`define IOEXP_TICK_DIV      4
`define IOEXP_REFRESH_TICKS 1024
`define IOEXP_ADDR          7'h20

`endif

//--- sdr_frontend_pkg.sv
`default_nettype none

`include "sdr_frontend_macros.svh"

package sdr_frontend_pkg;

    // Signed two's complement sample, ADC in and DAC out
    typedef logic signed [`SDR_SAMPLE_BITS-1:0] sample_t;

    // Oscillator phase and per-cycle step
    typedef logic [`SDR_PHASE_BITS-1:0] phase_t;
    typedef logic [`SDR_PHASE_BITS-1:0] freq_word_t;

    // Right shift of 0 to 3
    typedef logic [1:0] att_t;

    // 0 zero, 1 ADC A, 2 ADC B, 3 DDS
    typedef logic [1:0] src_sel_t;

    // APB bus
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Front-panel expander word
    typedef logic [15:0] ioexp_word_t;

    // Frame sequencer states
    typedef enum logic [1:0] {IDLE, START, SHIFT, STOP} ioexp_state_t;

endpackage

`default_nettype wire

//--- sdr_regs.sv
`default_nettype none

`include "sdr_frontend_macros.svh"

module sdr_regs (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  sdr_frontend_pkg::apb_addr_t  paddr_i,
    input  sdr_frontend_pkg::apb_data_t  pwdata_i,
    input  logic                         ovr_a_i,
    input  logic                         ovr_b_i,
    output sdr_frontend_pkg::apb_data_t  prdata_o,
    output sdr_frontend_pkg::src_sel_t   cha_src_o,
    output sdr_frontend_pkg::src_sel_t   chb_src_o,
    output sdr_frontend_pkg::att_t       cha_att_o,
    output sdr_frontend_pkg::att_t       chb_att_o,
    output logic                         cha_amp_en_o,
    output logic                         chb_amp_en_o,
    output sdr_frontend_pkg::freq_word_t dds_freq_o,
    output logic [1:0]                   ovr_sticky_o
);
    import sdr_frontend_pkg::*;

    logic       win_hit;
    logic [3:0] page;
    logic       off_zero;
    logic       wr_en;
    logic [1:0] ovr_clr;

    // Control fields: [4] amp enable, [3:2] attenuation, [1:0] source
    logic [4:0] cha_ctrl_q;
    logic [4:0] chb_ctrl_q;
    freq_word_t dds_freq_q;
    logic [1:0] ovr_q;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    // Only the 43C0 window answers
    assign win_hit  = (paddr_i[31:16] == `SDR_APB_WINDOW);
    assign page     = paddr_i[15:12];
    // One register per page, at offset 0
    assign off_zero = (paddr_i[3:2] == 2'd0);

    // Zero wait state, write lands on the edge closing the access phase
    assign wr_en = psel_i && penable_i && pwrite_i && win_hit && off_zero;

    // Write-one-to-clear on the status page
    assign ovr_clr = (wr_en && (page == `SDR_PAGE_STATUS)) ? pwdata_i[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cha_ctrl_q <= '0;
            chb_ctrl_q <= '0;
            dds_freq_q <= '0;
            ovr_q      <= '0;
        end else begin
            if (wr_en && (page == `SDR_PAGE_CHA)) begin
                cha_ctrl_q <= pwdata_i[4:0];
            end
            if (wr_en && (page == `SDR_PAGE_CHB)) begin
                chb_ctrl_q <= pwdata_i[4:0];
            end
            if (wr_en && (page == `SDR_PAGE_DDS)) begin
                dds_freq_q <= pwdata_i;
            end
            // Set beats clear when both hit in one cycle
            ovr_q <= (ovr_q & ~ovr_clr) | {ovr_b_i, ovr_a_i};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        prdata_o = '0;
        if (psel_i && win_hit && off_zero) begin
            case (page)
                `SDR_PAGE_CHA:    prdata_o = {27'd0, cha_ctrl_q};
                `SDR_PAGE_CHB:    prdata_o = {27'd0, chb_ctrl_q};
                `SDR_PAGE_DDS:    prdata_o = dds_freq_q;
                `SDR_PAGE_STATUS: prdata_o = {30'd0, ovr_q};
                default:          prdata_o = '0;
            endcase
        end
    end

    // Field breakout
    assign cha_src_o    = cha_ctrl_q[1:0];
    assign cha_att_o    = cha_ctrl_q[3:2];
    assign cha_amp_en_o = cha_ctrl_q[4];
    assign chb_src_o    = chb_ctrl_q[1:0];
    assign chb_att_o    = chb_ctrl_q[3:2];
    assign chb_amp_en_o = chb_ctrl_q[4];
    assign dds_freq_o   = dds_freq_q;
    assign ovr_sticky_o = ovr_q;

endmodule

`default_nettype wire

//--- dds_nco.sv
`default_nettype none

`include "sdr_frontend_macros.svh"

module dds_nco (
    input  logic                         clk,
    input  logic                         reset_i,
    input  sdr_frontend_pkg::freq_word_t freq_i,
    output sdr_frontend_pkg::sample_t    sample_o
);
    import sdr_frontend_pkg::*;

    phase_t  phase_q;
    sample_t sample_q;
    logic [`SDR_SAMPLE_BITS-1:0] top_byte;

    // Top byte of the accumulator is an offset binary ramp
    assign top_byte = phase_q[`SDR_PHASE_BITS-1 -: `SDR_SAMPLE_BITS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase_q  <= '0;
            sample_q <= '0;
        end else begin
            // Wraps modulo 2^32
            phase_q  <= phase_q + freq_i;
            // Flip MSB, offset binary to two's complement
            sample_q <= {~top_byte[`SDR_SAMPLE_BITS-1], top_byte[`SDR_SAMPLE_BITS-2:0]};
        end
    end

    assign sample_o = sample_q;

endmodule

`default_nettype wire

//--- dac_channel.sv
`default_nettype none

module dac_channel (
    input  logic                       clk,
    input  logic                       reset_i,
    input  sdr_frontend_pkg::src_sel_t src_i,
    input  sdr_frontend_pkg::att_t     att_i,
    input  sdr_frontend_pkg::sample_t  adc_a_i,
    input  sdr_frontend_pkg::sample_t  adc_b_i,
    input  sdr_frontend_pkg::sample_t  dds_i,
    output sdr_frontend_pkg::sample_t  dac_o
);
    import sdr_frontend_pkg::*;

    sample_t sel_s;
    sample_t att_s;
    sample_t dac_q;

    // Source mux
    always_comb begin
        case (src_i)
            2'd1:    sel_s = adc_a_i;
            2'd2:    sel_s = adc_b_i;
            2'd3:    sel_s = dds_i;
            // Code 0 mutes the channel
            default: sel_s = '0;
        endcase
    end

    // Sign-preserving attenuation, 6 dB per step
    assign att_s = sel_s >>> att_i;

    // Single output stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dac_q <= '0;
        end else begin
            dac_q <= att_s;
        end
    end

    assign dac_o = dac_q;

endmodule

`default_nettype wire

//--- ioexp_timer.sv
`default_nettype none

`include "sdr_frontend_macros.svh"

module ioexp_timer (
    input  logic clk,
    input  logic reset_i,
    output logic tick_o,
    output logic refresh_o
);

    localparam int DIV_W = $clog2(`IOEXP_TICK_DIV);
    localparam int REF_W = $clog2(`IOEXP_REFRESH_TICKS);

    logic [DIV_W-1:0] div_cnt_q;
    logic [REF_W-1:0] ref_cnt_q;

    // Quarter-bit strobe on the last divider count
    assign tick_o = (div_cnt_q == DIV_W'(`IOEXP_TICK_DIV - 1));

    // Refresh coincides with the closing tick of the period
    assign refresh_o = tick_o && (ref_cnt_q == REF_W'(`IOEXP_REFRESH_TICKS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_cnt_q <= '0;
            ref_cnt_q <= '0;
        end else begin
            // Clock divider
            if (tick_o) begin
                div_cnt_q <= '0;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
            // Tick counter, explicit wrap
            if (refresh_o) begin
                ref_cnt_q <= '0;
            end else if (tick_o) begin
                ref_cnt_q <= ref_cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- ioexp_fsm.sv
`default_nettype none

`include "sdr_frontend_macros.svh"

module ioexp_fsm (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          tick_i,
    input  logic                          refresh_i,
    input  sdr_frontend_pkg::ioexp_word_t word_i,
    output logic                          scl_o,
    output logic                          sda_o
);
    import sdr_frontend_pkg::*;

    // Address+W, ack, low byte, ack, high byte, ack
    localparam int FRAME_BITS = 27;

    ioexp_state_t            state_q;
    logic [1:0]              qtr_q;
    logic [4:0]              bit_cnt_q;
    logic [FRAME_BITS-1:0]   frame_q;
    ioexp_word_t             last_q;
    logic                    scl_q;
    logic                    sda_q;
    logic                    start_req;

    // New frame on periodic refresh or on a word change
    assign start_req = refresh_i || (word_i != last_q);

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= IDLE;
            qtr_q     <= '0;
            bit_cnt_q <= '0;
            last_q    <= '0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_req) begin
                        state_q <= START;
                        qtr_q   <= '0;
                        last_q  <= word_i;
                    end
                end
                START: begin
                    if (tick_i) begin
                        qtr_q <= qtr_q + 1'b1;
                        case (qtr_q)
                            // Start condition, sda falls under high scl
                            2'd0: sda_q <= 1'b0;
                            2'd2: scl_q <= 1'b0;
                            2'd3: begin
                                state_q   <= SHIFT;
                                bit_cnt_q <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                SHIFT: begin
                    if (tick_i) begin
                        qtr_q <= qtr_q + 1'b1;
                        case (qtr_q)
                            // Data moves mid low phase
                            2'd0: sda_q <= frame_q[FRAME_BITS-1];
                            2'd1: scl_q <= 1'b1;
                            2'd3: begin
                                scl_q <= 1'b0;
                                if (bit_cnt_q == 5'(FRAME_BITS - 1)) begin
                                    state_q <= STOP;
                                end else begin
                                    bit_cnt_q <= bit_cnt_q + 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                STOP: begin
                    if (tick_i) begin
                        qtr_q <= qtr_q + 1'b1;
                        case (qtr_q)
                            2'd0: sda_q <= 1'b0;
                            2'd1: scl_q <= 1'b1;
                            // Stop condition, sda rises under high scl
                            2'd2: sda_q <= 1'b1;
                            2'd3: state_q <= IDLE;
                            default: ;
                        endcase
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Frame shifter, MSB first
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && start_req) begin
            frame_q <= {`IOEXP_ADDR, 1'b0, 1'b1, word_i[7:0], 1'b1, word_i[15:8], 1'b1};
        end else if ((state_q == SHIFT) && tick_i && (qtr_q == 2'd0)) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], 1'b1};
        end
    end

    assign scl_o = scl_q;
    assign sda_o = sda_q;

endmodule

`default_nettype wire

//--- sdr_frontend_top.sv
`default_nettype none

module sdr_frontend_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  sdr_frontend_pkg::apb_addr_t paddr_i,
    input  sdr_frontend_pkg::apb_data_t pwdata_i,
    output sdr_frontend_pkg::apb_data_t prdata_o,
    input  sdr_frontend_pkg::sample_t   adc_a_data_i,
    input  sdr_frontend_pkg::sample_t   adc_b_data_i,
    input  logic                        adc_a_dor_i,
    input  logic                        adc_b_dor_i,
    output sdr_frontend_pkg::sample_t   dac_a_data_o,
    output sdr_frontend_pkg::sample_t   dac_b_data_o,
    output logic                        ioexp_scl_o,
    output logic                        ioexp_sda_o
);
    import sdr_frontend_pkg::*;

    src_sel_t    cha_src;
    src_sel_t    chb_src;
    att_t        cha_att;
    att_t        chb_att;
    logic        cha_amp_en;
    logic        chb_amp_en;
    freq_word_t  dds_freq;
    logic [1:0]  ovr_sticky;
    sample_t     dds_sample;
    logic        tick;
    logic        refresh;
    ioexp_word_t panel_word;

    ////////////////////////////////////////////////////////////////////////////
    // Registers and oscillator
    ////////////////////////////////////////////////////////////////////////////

    sdr_regs u_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .ovr_a_i      (adc_a_dor_i),
        .ovr_b_i      (adc_b_dor_i),
        .prdata_o     (prdata_o),
        .cha_src_o    (cha_src),
        .chb_src_o    (chb_src),
        .cha_att_o    (cha_att),
        .chb_att_o    (chb_att),
        .cha_amp_en_o (cha_amp_en),
        .chb_amp_en_o (chb_amp_en),
        .dds_freq_o   (dds_freq),
        .ovr_sticky_o (ovr_sticky)
    );

    dds_nco u_dds (
        .clk      (clk),
        .reset_i  (reset_i),
        .freq_i   (dds_freq),
        .sample_o (dds_sample)
    );

    // Output channels, both fed the same sources
    dac_channel u_dac_a (
        .clk     (clk),
        .reset_i (reset_i),
        .src_i   (cha_src),
        .att_i   (cha_att),
        .adc_a_i (adc_a_data_i),
        .adc_b_i (adc_b_data_i),
        .dds_i   (dds_sample),
        .dac_o   (dac_a_data_o)
    );

    dac_channel u_dac_b (
        .clk     (clk),
        .reset_i (reset_i),
        .src_i   (chb_src),
        .att_i   (chb_att),
        .adc_a_i (adc_a_data_i),
        .adc_b_i (adc_b_data_i),
        .dds_i   (dds_sample),
        .dac_o   (dac_b_data_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Front-panel expander
    ////////////////////////////////////////////////////////////////////////////

    // Port 0 is channel A, port 1 is channel B; LED follows sticky overrange
    assign panel_word = {4'b0000, ovr_sticky[1], chb_amp_en, chb_att,
                         4'b0000, ovr_sticky[0], cha_amp_en, cha_att};

    ioexp_timer u_timer (
        .clk       (clk),
        .reset_i   (reset_i),
        .tick_o    (tick),
        .refresh_o (refresh)
    );

    ioexp_fsm u_fsm (
        .clk       (clk),
        .reset_i   (reset_i),
        .tick_i    (tick),
        .refresh_i (refresh),
        .word_i    (panel_word),
        .scl_o     (ioexp_scl_o),
        .sda_o     (ioexp_sda_o)
    );

endmodule

`default_nettype wire

//--- sdr_frontend_asserts.sv
`default_nettype none

module sdr_frontend_asserts (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           ioexp_scl_o,
    input  logic                           ioexp_sda_o,
    input  sdr_frontend_pkg::sample_t      dac_a_data_o,
    input  sdr_frontend_pkg::sample_t      dac_b_data_o,
    input  sdr_frontend_pkg::ioexp_state_t fsm_state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import sdr_frontend_pkg::*;

    // Bus idles high once reset has been applied
    link_idle_after_reset: assert property (@(posedge clk)
        $past(reset_i) |-> (ioexp_scl_o && ioexp_sda_o))
        else $error("expander link not idle after reset");

    // Both DAC registers come out of reset at zero
    dac_zero_after_reset: assert property (@(posedge clk)
        $past(reset_i) |-> ((dac_a_data_o == '0) && (dac_b_data_o == '0)))
        else $error("DAC output not zero after reset");

    // sda moves under high scl only as start (fall) or stop (rise)
    sda_stable_under_scl: assert property (@(posedge clk) disable iff (reset_i)
        ((ioexp_sda_o != $past(ioexp_sda_o)) && ioexp_scl_o && $past(ioexp_scl_o))
        |-> (((fsm_state_i == START) && !ioexp_sda_o)
             || ((fsm_state_i == STOP) && ioexp_sda_o)))
        else $error("sda changed while scl high outside start or stop");

endmodule

bind sdr_frontend_top sdr_frontend_asserts i_asserts (
    .clk          (clk),
    .reset_i      (reset_i),
    .ioexp_scl_o  (ioexp_scl_o),
    .ioexp_sda_o  (ioexp_sda_o),
    .dac_a_data_o (dac_a_data_o),
    .dac_b_data_o (dac_b_data_o),
    .fsm_state_i  (u_fsm.state_q)
);

`default_nettype wire

//--- tb_sdr_frontend.sv
`default_nettype none

`include "sdr_frontend_macros.svh"

module tb_sdr_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    import sdr_frontend_pkg::*;

    // Start wait covers one refresh period plus one frame, counted in clocks
    localparam int START_TIMEOUT = (`IOEXP_REFRESH_TICKS + 120) * `IOEXP_TICK_DIV;
    localparam int FRAME_TIMEOUT = 120 * `IOEXP_TICK_DIV;

    logic      clk;
    logic      reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    sample_t   adc_a_data;
    sample_t   adc_b_data;
    logic      adc_a_dor;
    logic      adc_b_dor;
    sample_t   dac_a_data;
    sample_t   dac_b_data;
    logic      ioexp_scl;
    logic      ioexp_sda;

    int seed = 32'h2b15;
    int check_cnt = 0;
    int err_cnt = 0;
    int test_cnt = 0;
    int err_start;

    sdr_frontend_top i_dut (
        .clk          (clk),
        .reset_i      (reset),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .adc_a_data_i (adc_a_data),
        .adc_b_data_i (adc_b_data),
        .adc_a_dor_i  (adc_a_dor),
        .adc_b_dor_i  (adc_b_dor),
        .dac_a_data_o (dac_a_data),
        .dac_b_data_o (dac_b_data),
        .ioexp_scl_o  (ioexp_scl),
        .ioexp_sda_o  (ioexp_sda)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Page base inside the 43C0 window
    function automatic apb_addr_t reg_addr(input logic [3:0] page);
        return {`SDR_APB_WINDOW, page, 12'h000};
    endfunction

    // Write lands on the edge that closes the access cycle
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // Read data settles by mid access cycle
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Expected DAC value with the sign kept through the shift
    function automatic sample_t shift_sample(input sample_t s, input int k);
        logic signed [7:0] t;
        t = s;
        return t >>> k;
    endfunction

    // Front-panel layout with channel A in the low byte
    function automatic ioexp_word_t pack_panel(input logic [1:0] att_a, input logic amp_a,
                                               input logic ovr_a, input logic [1:0] att_b,
                                               input logic amp_b, input logic ovr_b);
        ioexp_word_t w;
        w        = '0;
        w[1:0]   = att_a;
        w[2]     = amp_a;
        w[3]     = ovr_a;
        w[9:8]   = att_b;
        w[10]    = amp_b;
        w[11]    = ovr_b;
        return w;
    endfunction

    // Collect bits on scl rises between a start and a stop
    task automatic decode_frame(output logic [26:0] bits, output bit ok);
        logic scl_prev;
        logic sda_prev;
        int   n_bits;
        int   cyc;
        bit   started;
        bit   stopped;
        ok      = 1'b0;
        bits    = '0;
        n_bits  = 0;
        started = 1'b0;
        stopped = 1'b0;
        @(negedge clk);
        scl_prev = ioexp_scl;
        sda_prev = ioexp_sda;
        cyc = 0;
        while (!started && (cyc < START_TIMEOUT)) begin
            @(negedge clk);
            cyc++;
            // Start is sda falling with scl held high
            started  = scl_prev && ioexp_scl && sda_prev && !ioexp_sda;
            scl_prev = ioexp_scl;
            sda_prev = ioexp_sda;
        end
        assert (started) else begin
            $display("ERROR: no start condition seen on the expander link in time");
            err_cnt++;
        end
        if (!started) return;
        cyc = 0;
        while (!stopped && (cyc < FRAME_TIMEOUT)) begin
            @(negedge clk);
            cyc++;
            if (!scl_prev && ioexp_scl) begin
                if (n_bits < 27) begin
                    bits = {bits[25:0], ioexp_sda};
                end
                n_bits++;
            end
            stopped  = scl_prev && ioexp_scl && !sda_prev && ioexp_sda;
            scl_prev = ioexp_scl;
            sda_prev = ioexp_sda;
        end
        assert (stopped) else begin
            $display("ERROR: expander frame did not end with a stop in time");
            err_cnt++;
        end
        // 27 frame bits plus the clock of the stop
        check_value("frame bit count", 32'd28, 32'(n_bits));
        ok = stopped;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_test();
        err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, err_cnt - err_start);
    endtask

    task automatic readback_regs();
        apb_data_t va;
        apb_data_t vb;
        apb_data_t vf;
        apb_data_t rd;
        begin_test();
        va = $random(seed);
        vb = $random(seed);
        vf = $random(seed);
        apb_write(reg_addr(`SDR_PAGE_CHA), va);
        apb_write(reg_addr(`SDR_PAGE_CHB), vb);
        apb_write(reg_addr(`SDR_PAGE_DDS), vf);
        apb_read(reg_addr(`SDR_PAGE_CHA), rd);
        check_value("readback cha", va & 32'h1f, rd);
        apb_read(reg_addr(`SDR_PAGE_CHB), rd);
        check_value("readback chb", vb & 32'h1f, rd);
        apb_read(reg_addr(`SDR_PAGE_DDS), rd);
        check_value("readback dds", vf, rd);
        // Next window up must be ignored
        apb_write({16'h43C1, 4'h0, 12'h000}, ~va);
        apb_read(reg_addr(`SDR_PAGE_CHA), rd);
        check_value("readback outside window", va & 32'h1f, rd);
        apb_read(reg_addr(`SDR_PAGE_DDS) | 32'h4, rd);
        check_value("readback unmapped", 32'd0, rd);
        end_test("register readback");
    endtask

    task automatic adc_loopthrough();
        sample_t sa;
        sample_t sb;
        begin_test();
        for (int k = 0; k < 4; k++) begin
            apb_write(reg_addr(`SDR_PAGE_CHA), {27'd0, 1'b0, 2'(k), 2'd1});
            apb_write(reg_addr(`SDR_PAGE_CHB), {27'd0, 1'b0, 2'(k), 2'd2});
            for (int n = 0; n < 3; n++) begin
                sa = sample_t'($random(seed));
                sb = sample_t'($random(seed));
                @(posedge clk);
                adc_a_data <= sa;
                adc_b_data <= sb;
                wait_cycles(3);
                @(negedge clk);
                check_value("loop cha", 32'(shift_sample(sa, k)), 32'(dac_a_data));
                check_value("loop chb", 32'(shift_sample(sb, k)), 32'(dac_b_data));
            end
        end
        // Source code 0 mutes
        apb_write(reg_addr(`SDR_PAGE_CHA), 32'd0);
        wait_cycles(3);
        @(negedge clk);
        check_value("loop zero source", 32'd0, 32'(dac_a_data));
        end_test("adc loop-through");
    endtask

    task automatic dds_sawtooth();
        sample_t prev;
        begin_test();
        apb_write(reg_addr(`SDR_PAGE_DDS), 32'h0100_0000);
        apb_write(reg_addr(`SDR_PAGE_CHA), 32'h0000_0003);
        wait_cycles(3);
        @(negedge clk);
        prev = dac_a_data;
        // Top byte steps by one per clock
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("dds step", 32'd1, 32'(8'(dac_a_data - prev)));
            prev = dac_a_data;
        end
        apb_write(reg_addr(`SDR_PAGE_DDS), 32'd0);
        wait_cycles(3);
        @(negedge clk);
        prev = dac_a_data;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("dds hold", 32'(prev), 32'(dac_a_data));
        end
        end_test("dds sawtooth");
    endtask

    task automatic sticky_overrange();
        apb_data_t rd;
        begin_test();
        @(posedge clk);
        adc_a_dor <= 1'b1;
        @(posedge clk);
        adc_a_dor <= 1'b0;
        apb_read(reg_addr(`SDR_PAGE_STATUS), rd);
        check_value("overrange set", 32'd1, rd);
        apb_write(reg_addr(`SDR_PAGE_STATUS), 32'd1);
        apb_read(reg_addr(`SDR_PAGE_STATUS), rd);
        check_value("overrange clear", 32'd0, rd);
        end_test("sticky overrange");
    endtask

    task automatic panel_frame();
        logic [26:0] bits;
        bit          ok;
        bit          match;
        ioexp_word_t exp;
        ioexp_word_t got;
        begin_test();
        match = 1'b0;
        got   = '0;
        @(posedge clk);
        adc_a_dor <= 1'b1;
        @(posedge clk);
        adc_a_dor <= 1'b0;
        // Amps on for both channels with att 2 on A and att 1 on B
        apb_write(reg_addr(`SDR_PAGE_CHA), 32'h19);
        apb_write(reg_addr(`SDR_PAGE_CHB), 32'h16);
        exp = pack_panel(2'd2, 1'b1, 1'b1, 2'd1, 1'b1, 1'b0);
        // Earlier frames may carry a partial update
        for (int f = 0; (f < 4) && !match; f++) begin
            decode_frame(bits, ok);
            if (ok) begin
                got   = {bits[8:1], bits[17:10]};
                match = (got == exp);
                check_value("frame address", 32'h40, 32'(bits[26:19]));
                check_value("frame acks", 32'h7, {29'd0, bits[18], bits[9], bits[0]});
            end
        end
        check_value("frame word", 32'(exp), 32'(got));
        end_test("front-panel frame");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        adc_a_data = '0;
        adc_b_data = '0;
        adc_a_dor  = 1'b0;
        adc_b_dor  = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        readback_regs();
        adc_loopthrough();
        dds_sawtooth();
        sticky_overrange();
        panel_frame();
        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sdr_frontend.f
+incdir+.
sdr_frontend_pkg.sv
sdr_regs.sv
dds_nco.sv
dac_channel.sv
ioexp_timer.sv
ioexp_fsm.sv
sdr_frontend_top.sv
sdr_frontend_asserts.sv
tb_sdr_frontend.sv

//--- Bender.yml
package:
  name: sdr_frontend

sources:
  - include_dirs:
      - .
    files:
      - sdr_frontend_pkg.sv
      - sdr_regs.sv
      - dds_nco.sv
      - dac_channel.sv
      - ioexp_timer.sv
      - ioexp_fsm.sv
      - sdr_frontend_top.sv
      - target: test
        files:
          - sdr_frontend_asserts.sv
          - tb_sdr_frontend.sv
